/* verilog/pci_defs.svh */
`ifndef PCI_DEFS_SVH
`define PCI_DEFS_SVH

// Shared word memory geometry
`define PCI_MEM_WORDS 1024
`define PCI_ADDR_W    10

// Host command opcodes
`define PCI_OP_WRITE  8'h01
`define PCI_OP_READ   8'h02
`define PCI_OP_RUN    8'h03   // Release the core
`define PCI_OP_HOLD   8'h04   // Put the core back in reset

// Single-byte status replies
`define PCI_RSP_OK    8'hAA
`define PCI_RSP_BAD   8'hEE

`endif

/* verilog/pci_pkg.sv */
`include "pci_defs.svh"

package pci_pkg;

    typedef logic [7:0]             byte_t;      // Host command or reply byte
    typedef logic [31:0]            word_t;
    typedef logic [`PCI_ADDR_W-1:0] mem_addr_t;  // Word index into shared memory

    // Request toward the shared memory, held until done
    typedef struct packed {
        logic      valid;
        logic      we;
        mem_addr_t addr;
        word_t     wdata;
    } mem_req_t;

    typedef struct packed {
        logic  done;   // One-cycle pulse
        word_t rdata;
    } mem_rsp_t;

    // Wishbone classic request signals from the core
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] addr;   // Byte address
        word_t       data;
    } core_bus_req_t;

    typedef enum logic [2:0] {
        IDLE,
        ADDR_HI,
        ADDR_LO,
        DATA,
        MEM_WAIT,
        SEND
    } host_state_e;

endpackage

/* verilog/host_cmd_unit.sv */
`timescale 1ns/1ns
`include "pci_defs.svh"

module host_cmd_unit (
    input  logic              sys_clk,
    input  logic              reset_i,
    input  logic              rx_valid_i,
    input  pci_pkg::byte_t    rx_byte_i,
    output logic              tx_valid_o,
    output pci_pkg::byte_t    tx_byte_o,
    output logic              core_rst_o,
    output pci_pkg::mem_req_t mem_req_o,
    input  pci_pkg::mem_rsp_t mem_rsp_i
);

    pci_pkg::host_state_e state_q;
    pci_pkg::byte_t       opcode_q;
    logic [15:0]          addr_bytes_q;   // Both address bytes, high first
    pci_pkg::word_t       wdata_q;
    pci_pkg::word_t       shift_q;        // Remaining read bytes
    logic [1:0]           cnt_q;
    logic                 req_valid_q;
    logic                 tx_valid_q;
    pci_pkg::byte_t       tx_byte_q;
    logic                 core_rst_q;
    logic                 is_write;

    assign is_write = (opcode_q == `PCI_OP_WRITE);

    always_comb begin
        mem_req_o.valid = req_valid_q;
        mem_req_o.we    = is_write;
        mem_req_o.addr  = addr_bytes_q[`PCI_ADDR_W-1:0];   // Upper address bits ignored
        mem_req_o.wdata = wdata_q;
    end

    assign tx_valid_o = tx_valid_q;
    assign tx_byte_o  = tx_byte_q;
    assign core_rst_o = core_rst_q;

    // Command FSM and control flags
    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            state_q     <= pci_pkg::IDLE;
            req_valid_q <= 1'b0;
            tx_valid_q  <= 1'b0;
            core_rst_q  <= 1'b1;   // Core held until a run command
            cnt_q       <= 2'd0;
        end else begin
            tx_valid_q <= 1'b0;
            case (state_q)
                pci_pkg::IDLE: begin
                    if (rx_valid_i) begin
                        case (rx_byte_i)
                            `PCI_OP_WRITE, `PCI_OP_READ: begin
                                state_q <= pci_pkg::ADDR_HI;
                            end
                            `PCI_OP_RUN: begin
                                core_rst_q <= 1'b0;
                                tx_valid_q <= 1'b1;
                            end
                            `PCI_OP_HOLD: begin
                                core_rst_q <= 1'b1;
                                tx_valid_q <= 1'b1;
                            end
                            default: tx_valid_q <= 1'b1;   // Bad opcode, stay in IDLE
                        endcase
                    end
                end
                pci_pkg::ADDR_HI: begin
                    if (rx_valid_i) begin
                        state_q <= pci_pkg::ADDR_LO;
                    end
                end
                pci_pkg::ADDR_LO: begin
                    if (rx_valid_i) begin
                        cnt_q <= 2'd0;
                        if (is_write) begin
                            state_q <= pci_pkg::DATA;
                        end else begin
                            state_q     <= pci_pkg::MEM_WAIT;
                            req_valid_q <= 1'b1;
                        end
                    end
                end
                pci_pkg::DATA: begin
                    if (rx_valid_i) begin
                        cnt_q <= cnt_q + 2'd1;
                        if (cnt_q == 2'd3) begin   // Last data byte
                            state_q     <= pci_pkg::MEM_WAIT;
                            req_valid_q <= 1'b1;
                        end
                    end
                end
                pci_pkg::MEM_WAIT: begin
                    if (mem_rsp_i.done) begin
                        req_valid_q <= 1'b0;
                        tx_valid_q  <= 1'b1;
                        cnt_q       <= is_write ? 2'd0 : 2'd3;
                        state_q     <= pci_pkg::SEND;
                    end
                end
                pci_pkg::SEND: begin
                    // cnt_q holds the bytes still to go after the current one
                    if (cnt_q == 2'd0) begin
                        state_q <= pci_pkg::IDLE;
                    end else begin
                        tx_valid_q <= 1'b1;
                        cnt_q      <= cnt_q - 2'd1;
                    end
                end
                default: state_q <= pci_pkg::IDLE;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge sys_clk) begin
        case (state_q)
            pci_pkg::IDLE: begin
                if (rx_valid_i) begin
                    opcode_q  <= rx_byte_i;
                    tx_byte_q <= (rx_byte_i == `PCI_OP_RUN || rx_byte_i == `PCI_OP_HOLD) ?
                                 `PCI_RSP_OK : `PCI_RSP_BAD;
                end
            end
            pci_pkg::ADDR_HI, pci_pkg::ADDR_LO: begin
                if (rx_valid_i) begin
                    addr_bytes_q <= {addr_bytes_q[7:0], rx_byte_i};
                end
            end
            pci_pkg::DATA: begin
                if (rx_valid_i) begin
                    wdata_q <= {wdata_q[23:0], rx_byte_i};   // MSB first
                end
            end
            pci_pkg::MEM_WAIT: begin
                if (mem_rsp_i.done) begin
                    tx_byte_q <= is_write ? `PCI_RSP_OK : mem_rsp_i.rdata[31:24];
                    shift_q   <= {mem_rsp_i.rdata[23:0], 8'h00};
                end
            end
            pci_pkg::SEND: begin
                tx_byte_q <= shift_q[31:24];
                shift_q   <= {shift_q[23:0], 8'h00};
            end
            default: ;
        endcase
    end

    // Replies seen in IDLE come only from run, hold or a bad opcode
    assert property (@(posedge sys_clk) disable iff (reset_i)
        (tx_valid_o && state_q == pci_pkg::IDLE) |->
            $past(rx_valid_i && state_q == pci_pkg::IDLE));

endmodule

/* verilog/core_bus_port.sv */
`timescale 1ns/1ns
`include "pci_defs.svh"

module core_bus_port (
    input  logic                   sys_clk,
    input  logic                   reset_i,
    input  pci_pkg::core_bus_req_t bus_i,
    output pci_pkg::word_t         core_data_o,
    output logic                   core_ack_o,
    output pci_pkg::mem_req_t      mem_req_o,
    input  pci_pkg::mem_rsp_t      mem_rsp_i
);

    logic           busy_q;      // Memory request outstanding
    logic           ack_q;
    logic           recover_q;   // Idle cycle after the ack
    logic           new_cycle;
    pci_pkg::word_t rdata_q;

    // A held stb starts only one request per bus cycle
    assign new_cycle = bus_i.cyc & bus_i.stb & ~busy_q & ~ack_q & ~recover_q;

    always_comb begin
        mem_req_o.valid = (new_cycle | busy_q) & ~mem_rsp_i.done;
        mem_req_o.we    = bus_i.we;
        mem_req_o.addr  = bus_i.addr[`PCI_ADDR_W+1:2];   // Byte to word address
        mem_req_o.wdata = bus_i.data;
    end

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            busy_q    <= 1'b0;
            ack_q     <= 1'b0;
            recover_q <= 1'b0;
        end else begin
            busy_q    <= (busy_q | new_cycle) & ~mem_rsp_i.done;
            ack_q     <= mem_rsp_i.done;
            recover_q <= ack_q;
        end
    end

    // Read data for the core
    always_ff @(posedge sys_clk) begin
        if (mem_rsp_i.done) begin
            rdata_q <= mem_rsp_i.rdata;
        end
    end

    assign core_ack_o  = ack_q;
    assign core_data_o = rdata_q;

    // The core keeps its request up until it sees the ack
    assert property (@(posedge sys_clk) disable iff (reset_i)
        core_ack_o |-> (bus_i.cyc && bus_i.stb));

endmodule

/* verilog/harness_mem.sv */
`timescale 1ns/1ns
`include "pci_defs.svh"

module harness_mem (
    input  logic              sys_clk,
    input  logic              reset_i,
    input  pci_pkg::mem_req_t host_req_i,
    input  pci_pkg::mem_req_t core_req_i,
    output pci_pkg::mem_rsp_t host_rsp_o,
    output pci_pkg::mem_rsp_t core_rsp_o
);

    pci_pkg::word_t    mem [`PCI_MEM_WORDS];
    pci_pkg::mem_req_t sel_req;
    pci_pkg::word_t    rdata_q;
    logic              host_go;
    logic              core_go;
    logic              gnt_host_q;   // Grant tag, one per requester
    logic              gnt_core_q;

    // A requester whose done pulses this cycle still shows valid,
    // so it is masked for that cycle
    assign host_go = host_req_i.valid & ~gnt_host_q;
    assign core_go = core_req_i.valid & ~gnt_core_q & ~host_go;   // Host wins

    assign sel_req = host_go ? host_req_i : core_req_i;

    // Word array with one access per cycle
    always_ff @(posedge sys_clk) begin
        if (host_go || core_go) begin
            if (sel_req.we) begin
                mem[sel_req.addr] <= sel_req.wdata;
            end
            rdata_q <= mem[sel_req.addr];
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            gnt_host_q <= 1'b0;
            gnt_core_q <= 1'b0;
        end else begin
            gnt_host_q <= host_go;
            gnt_core_q <= core_go;
        end
    end

    // Route the result to whoever was granted last cycle
    always_comb begin
        host_rsp_o.done  = gnt_host_q;
        host_rsp_o.rdata = rdata_q;
        core_rsp_o.done  = gnt_core_q;
        core_rsp_o.rdata = rdata_q;
    end

    // A core request that loses to the host stays pending
    assert property (@(posedge sys_clk) disable iff (reset_i)
        (core_req_i.valid && host_go) |=> core_req_i.valid);

endmodule

/* verilog/processorci_top.sv */
`timescale 1ns/1ns

module processorci_top (
    input  logic           sys_clk,
    input  logic           reset_i,

    // Host byte strobes
    input  logic           rx_valid_i,
    input  pci_pkg::byte_t rx_byte_i,
    output logic           tx_valid_o,
    output pci_pkg::byte_t tx_byte_o,

    output logic           core_rst_o,   // High holds the core

    // Wishbone classic bus from the core
    input  logic           core_cyc_i,
    input  logic           core_stb_i,
    input  logic           core_we_i,
    input  logic [31:0]    core_addr_i,
    input  pci_pkg::word_t core_data_i,
    output pci_pkg::word_t core_data_o,
    output logic           core_ack_o
);

    pci_pkg::core_bus_req_t core_bus;
    pci_pkg::mem_req_t      host_req;
    pci_pkg::mem_req_t      core_req;
    pci_pkg::mem_rsp_t      host_rsp;
    pci_pkg::mem_rsp_t      core_rsp;

    assign core_bus = '{cyc: core_cyc_i, stb: core_stb_i, we: core_we_i,
                        addr: core_addr_i, data: core_data_i};

    host_cmd_unit u_host_cmd (
        .sys_clk    (sys_clk),
        .reset_i    (reset_i),
        .rx_valid_i (rx_valid_i),
        .rx_byte_i  (rx_byte_i),
        .tx_valid_o (tx_valid_o),
        .tx_byte_o  (tx_byte_o),
        .core_rst_o (core_rst_o),
        .mem_req_o  (host_req),
        .mem_rsp_i  (host_rsp)
    );

    core_bus_port u_core_port (
        .sys_clk     (sys_clk),
        .reset_i     (reset_i),
        .bus_i       (core_bus),
        .core_data_o (core_data_o),
        .core_ack_o  (core_ack_o),
        .mem_req_o   (core_req),
        .mem_rsp_i   (core_rsp)
    );

    // Shared memory, host has priority
    harness_mem u_mem (
        .sys_clk    (sys_clk),
        .reset_i    (reset_i),
        .host_req_i (host_req),
        .core_req_i (core_req),
        .host_rsp_o (host_rsp),
        .core_rsp_o (core_rsp)
    );

endmodule

/* tb/tb_processorci.sv */
`timescale 1ns/1ns
`include "pci_defs.svh"

module tb_processorci;

    localparam int          TIMEOUT_CYCLES = 200;
    localparam logic [31:0] RND_SEED       = 32'h2e3a4ec2;

    logic           sys_clk = 1'b0;
    logic           reset_i;
    logic           rx_valid_i;
    pci_pkg::byte_t rx_byte_i;
    logic           tx_valid_o;
    pci_pkg::byte_t tx_byte_o;
    logic           core_rst_o;
    logic           core_cyc_i;
    logic           core_stb_i;
    logic           core_we_i;
    logic [31:0]    core_addr_i;
    pci_pkg::word_t core_data_i;
    pci_pkg::word_t core_data_o;
    logic           core_ack_o;

    pci_pkg::word_t     ref_mem [`PCI_MEM_WORDS];   // Expected memory contents
    pci_pkg::mem_addr_t written_q [$];
    int                 err_count  = 0;
    int                 tests_pass = 0;
    int                 tests_fail = 0;

    always #20 sys_clk = ~sys_clk;

    processorci_top UUT (
        .sys_clk     (sys_clk),
        .reset_i     (reset_i),
        .rx_valid_i  (rx_valid_i),
        .rx_byte_i   (rx_byte_i),
        .tx_valid_o  (tx_valid_o),
        .tx_byte_o   (tx_byte_o),
        .core_rst_o  (core_rst_o),
        .core_cyc_i  (core_cyc_i),
        .core_stb_i  (core_stb_i),
        .core_we_i   (core_we_i),
        .core_addr_i (core_addr_i),
        .core_data_i (core_data_i),
        .core_data_o (core_data_o),
        .core_ack_o  (core_ack_o)
    );

    task automatic check_byte(input string name, input pci_pkg::byte_t got,
                              input pci_pkg::byte_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%02h expected 0x%02h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_word(input string name, input pci_pkg::word_t got,
                              input pci_pkg::word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    // One byte strobe and a gap cycle
    task automatic host_send_byte(input pci_pkg::byte_t b);
        @(posedge sys_clk);
        rx_valid_i <= 1'b1;
        rx_byte_i  <= b;
        @(posedge sys_clk);
        rx_valid_i <= 1'b0;
    endtask

    // Low n bytes of exp MSB first with the later ones on consecutive cycles
    task automatic host_expect_bytes(input int n, input pci_pkg::word_t exp);
        int waited;
        for (int i = n - 1; i >= 0; i--) begin
            waited = 0;
            do begin
                @(negedge sys_clk);
                waited++;
            end while (!tx_valid_o && waited < TIMEOUT_CYCLES);
            if (!tx_valid_o) begin
                $display("Timeout waiting for reply byte %0d on tx_valid_o", n - 1 - i);
                err_count++;
                return;
            end
            if (i != n - 1 && waited != 1) begin
                $display("Reply bytes did not come on consecutive cycles");
                err_count++;
            end
            check_byte("tx_byte_o", tx_byte_o, exp[8*i +: 8]);
        end
    endtask

    task automatic host_control(input pci_pkg::byte_t op, input pci_pkg::byte_t rsp);
        host_send_byte(op);
        host_expect_bytes(1, {24'h0, rsp});
    endtask

    // Upper bits of the 16-bit address are ignored by the harness
    task automatic host_write(input logic [15:0] addr16, input pci_pkg::word_t data);
        host_send_byte(`PCI_OP_WRITE);
        host_send_byte(addr16[15:8]);
        host_send_byte(addr16[7:0]);
        for (int i = 3; i >= 0; i--) begin
            host_send_byte(data[8*i +: 8]);
        end
        ref_mem[addr16[`PCI_ADDR_W-1:0]] = data;
        host_expect_bytes(1, {24'h0, `PCI_RSP_OK});
    endtask

    task automatic host_read(input logic [15:0] addr16);
        host_send_byte(`PCI_OP_READ);
        host_send_byte(addr16[15:8]);
        host_send_byte(addr16[7:0]);
        host_expect_bytes(4, ref_mem[addr16[`PCI_ADDR_W-1:0]]);
    endtask

    // Holds cyc and stb until the ack
    task automatic bus_cycle(input logic we, input logic [31:0] addr,
                             input pci_pkg::word_t wdata, output logic acked,
                             output pci_pkg::word_t rdata);
        int waited;
        @(posedge sys_clk);
        core_cyc_i  <= 1'b1;
        core_stb_i  <= 1'b1;
        core_we_i   <= we;
        core_addr_i <= addr;
        core_data_i <= wdata;
        waited = 0;
        do begin
            @(negedge sys_clk);
            waited++;
        end while (!core_ack_o && waited < TIMEOUT_CYCLES);
        acked = core_ack_o;
        rdata = core_data_o;
        @(posedge sys_clk);
        core_cyc_i <= 1'b0;
        core_stb_i <= 1'b0;
        core_we_i  <= 1'b0;
        if (!acked) begin
            $display("Timeout waiting for core_ack_o at address 0x%08h", addr);
            err_count++;
        end
    endtask

    task automatic core_write(input logic [31:0] addr, input pci_pkg::word_t data);
        logic           acked;
        pci_pkg::word_t rdata;
        bus_cycle(1'b1, addr, data, acked, rdata);
        ref_mem[addr[11:2]] = data;   // Word index from byte address bits 11:2
    endtask

    task automatic core_read(input logic [31:0] addr);
        logic           acked;
        pci_pkg::word_t rdata;
        bus_cycle(1'b0, addr, 32'h0, acked, rdata);
        if (acked) begin
            check_word("core_data_o", rdata, ref_mem[addr[11:2]]);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_pass++;
            $display("Test %s: ok", name);
        end else begin
            tests_fail++;
            $display("Test %s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    initial begin
        int                 errs_before;
        int                 dly;
        logic [31:0]        rnd;
        pci_pkg::mem_addr_t ha;
        pci_pkg::mem_addr_t ca;
        pci_pkg::word_t     hd;
        pci_pkg::word_t     cd;

        rnd = $urandom(RND_SEED);
        reset_i     <= 1'b1;
        rx_valid_i  <= 1'b0;
        rx_byte_i   <= 8'h00;
        core_cyc_i  <= 1'b0;
        core_stb_i  <= 1'b0;
        core_we_i   <= 1'b0;
        core_addr_i <= 32'h0;
        core_data_i <= 32'h0;
        repeat (8) @(posedge sys_clk);
        reset_i <= 1'b0;

        errs_before = err_count;
        @(negedge sys_clk);
        check_bit("core_rst_o", core_rst_o, 1'b1);
        repeat (10) begin
            @(negedge sys_clk);
            check_bit("tx_valid_o", tx_valid_o, 1'b0);
            check_bit("core_ack_o", core_ack_o, 1'b0);
        end
        report_test("reset state", errs_before);

        errs_before = err_count;
        host_write(16'hFC35, 32'hDEAD_BEEF);   // Only the low 10 bits select the word
        host_read(16'h0035);
        report_test("host write and read", errs_before);

        errs_before = err_count;
        host_control(`PCI_OP_RUN, `PCI_RSP_OK);
        check_bit("core_rst_o", core_rst_o, 1'b0);
        host_control(`PCI_OP_HOLD, `PCI_RSP_OK);
        check_bit("core_rst_o", core_rst_o, 1'b1);
        report_test("run and hold", errs_before);

        errs_before = err_count;
        core_write(32'h8765_4010, 32'h1234_5678);   // Wraps to word 4
        host_read(16'h0004);
        core_read(32'h0000_0010);
        host_write(16'h03FF, 32'hCAFE_F00D);
        core_read(32'hFFFF_FFFC);
        report_test("shared memory between ports", errs_before);

        errs_before = err_count;
        host_control(8'h7F, `PCI_RSP_BAD);
        host_read(16'h0035);
        report_test("bad opcode recovery", errs_before);

        // Core cycle starts at a random point inside each host command
        errs_before = err_count;
        for (int i = 0; i < 10; i++) begin
            rnd = $urandom;
            ha  = rnd[9:0];
            rnd = $urandom;
            ca  = rnd[9:0];
            if (ca == ha) begin
                ca = ha + 10'd1;
            end
            hd  = $urandom;
            cd  = $urandom;
            dly = int'($urandom % 14);
            fork
                host_write({6'h15, ha}, hd);
                begin
                    repeat (dly) @(posedge sys_clk);
                    core_write({rnd[31:12], ca, 2'b00}, cd);
                end
            join
            written_q.push_back(ha);
            written_q.push_back(ca);
        end
        foreach (written_q[i]) begin
            if (i % 2 == 0) begin
                host_read({6'h00, written_q[i]});
            end else begin
                core_read({20'hABCDE, written_q[i], 2'b00});
            end
        end
        report_test("random traffic on both ports", errs_before);

        $display("Tests passed: %0d, failed: %0d, check errors: %0d",
                 tests_pass, tests_fail, err_count);
        if (err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+verilog
verilog/pci_pkg.sv
verilog/host_cmd_unit.sv
verilog/core_bus_port.sv
verilog/harness_mem.sv
verilog/processorci_top.sv
tb/tb_processorci.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run the testbench, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_processorci -f flist.f -o tb_sim > "$LOG" 2>&1 &&
./obj_dir/tb_sim >> "$LOG" 2>&1
grep -qx "=== PASS ===" "$LOG" && echo "Simulation passed" ||
{ echo "Simulation failed, see $LOG"; exit 1; }
